/* Bender.yml */
package:
  name: lsu_subsystem

sources:
  - lsu_pkg.sv
  - data_memory_interface.sv
  - data_memory.sv
  - lsu_request_queue.sv
  - lsu_access_stage.sv
  - lsu_response_queue.sv
  - lsu_subsystem.sv
  - target: test
    files:
      - lsu_tb.sv

/* data_memory.sv */
// ##################################################################
// data memory
// word RAM with per-byte write enables and a registered read port
// ##################################################################
`timescale 1ns/1ns

module data_memory #(
  parameter int mem_words = 256
) (
  input  logic                            clock,
  input  logic                            read_enable,
  input  logic                            write_enable,
  input  logic [lsu_pkg::byte_lanes-1:0]  byte_enable,
  input  logic [lsu_pkg::xlen-1:0]        address,
  input  logic [lsu_pkg::xlen-1:0]        write_data,
  output logic [lsu_pkg::xlen-1:0]        read_data
);

  localparam int offset_w = $clog2(lsu_pkg::byte_lanes);
  localparam int index_w  = $clog2(mem_words);

  logic [lsu_pkg::xlen-1:0] mem [mem_words];
  logic [index_w-1:0]       index;

  // word index sits above the byte offset
  assign index = address[offset_w +: index_w];

  always_ff @(posedge clock) begin
    if (write_enable) begin
      for (int b = 0; b < lsu_pkg::byte_lanes; b++) begin
        if (byte_enable[b]) begin
          mem[index][8*b +: 8] <= write_data[8*b +: 8];
        end
      end
    end
  end

  // old word on a same-edge write
  always_ff @(posedge clock) begin
    if (read_enable) begin
      read_data <= mem[index];
    end
  end

endmodule

/* data_memory_interface.sv */
// ##################################################################
// data memory interface
// aligns store data and byte enables onto the word bus, extracts
// and sign or zero extends load data from the returned word
// ##################################################################
`timescale 1ns/1ns

module data_memory_interface (
  input  logic                            read_enable,
  input  logic                            write_enable,
  input  lsu_pkg::data_format_t           data_format,
  input  logic [lsu_pkg::xlen-1:0]        address,
  input  logic [lsu_pkg::xlen-1:0]        write_data,
  output logic [lsu_pkg::xlen-1:0]        read_data,
  output logic [lsu_pkg::xlen-1:0]        bus_address,
  input  logic [lsu_pkg::xlen-1:0]        bus_read_data,
  output logic [lsu_pkg::xlen-1:0]        bus_write_data,
  output logic [lsu_pkg::byte_lanes-1:0]  bus_byte_enable,
  output logic                            bus_read_enable,
  output logic                            bus_write_enable
);

  localparam int offset_w = $clog2(lsu_pkg::byte_lanes);

  // lane masks before shifting to the byte offset
  localparam logic [lsu_pkg::byte_lanes-1:0] mask_byte = 'b1;
  localparam logic [lsu_pkg::byte_lanes-1:0] mask_half = 'b11;
  localparam logic [lsu_pkg::byte_lanes-1:0] mask_word = '1;

  logic [offset_w-1:0]       offset;
  logic [offset_w+2:0]       bit_shift;
  logic [lsu_pkg::xlen-1:0]  position_fix;
  logic                      sign_byte;
  logic                      sign_half;

  assign offset    = address[offset_w-1:0];
  assign bit_shift = {offset, 3'b000};

  assign bus_address      = address;
  assign bus_read_enable  = read_enable;
  assign bus_write_enable = write_enable;

  // lanes pushed past the top bit are dropped
  assign bus_write_data = write_data << bit_shift;

  always_comb begin
    case (data_format.fields.size)
      lsu_pkg::size_byte: bus_byte_enable = mask_byte << offset;
      lsu_pkg::size_half: bus_byte_enable = mask_half << offset;
      lsu_pkg::size_word: bus_byte_enable = mask_word << offset;
      default:            bus_byte_enable = '0;
    endcase
  end

  // bring the addressed lane down to bit 0
  assign position_fix = bus_read_data >> bit_shift;

  // sign bits, forced low for lbu and lhu
  assign sign_byte = ~data_format.fields.is_unsigned & position_fix[7];
  assign sign_half = ~data_format.fields.is_unsigned & position_fix[15];

  always_comb begin
    case (data_format.fields.size)
      lsu_pkg::size_byte: read_data = {{(lsu_pkg::xlen - 8){sign_byte}}, position_fix[7:0]};
      lsu_pkg::size_half: read_data = {{(lsu_pkg::xlen - 16){sign_half}}, position_fix[15:0]};
      lsu_pkg::size_word: read_data = position_fix;
      default:            read_data = '0;
    endcase
  end

endmodule

/* lsu_access_stage.sv */
// ##################################################################
// access stage of the load/store subsystem
// pops requests, writes stores, reads loads and extracts the result
// one cycle later with the held load context
// ##################################################################
`timescale 1ns/1ns

module lsu_access_stage #(
  parameter int mem_words = 256
) (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        head_valid,
  input  logic                        head_write,
  input  lsu_pkg::data_format_t       head_format,
  input  logic [lsu_pkg::xlen-1:0]    head_address,
  input  logic [lsu_pkg::xlen-1:0]    head_write_data,
  output logic                        pop,
  input  logic                        room,
  output logic                        push,
  output logic [lsu_pkg::xlen-1:0]    load_data
);

  logic                            take_store;
  logic                            take_load;
  logic                            load_pending;
  lsu_pkg::data_format_t           load_format;
  logic [lsu_pkg::xlen-1:0]        load_address;
  logic [lsu_pkg::xlen-1:0]        bus_address;
  logic [lsu_pkg::xlen-1:0]        bus_write_data;
  logic [lsu_pkg::byte_lanes-1:0]  bus_byte_enable;
  logic                            bus_read_enable;
  logic                            bus_write_enable;
  logic [lsu_pkg::xlen-1:0]        mem_read_data;

  // stores never wait, loads need space in the response queue
  assign take_store = head_valid & head_write;
  assign take_load  = head_valid & ~head_write & room;
  assign pop        = take_store | take_load;

  // request side alignment, drives the memory at the pop edge
  data_memory_interface align_req (
    .read_enable      (take_load),
    .write_enable     (take_store),
    .data_format      (head_format),
    .address          (head_address),
    .write_data       (head_write_data),
    .read_data        (),
    .bus_address      (bus_address),
    .bus_read_data    ('0),
    .bus_write_data   (bus_write_data),
    .bus_byte_enable  (bus_byte_enable),
    .bus_read_enable  (bus_read_enable),
    .bus_write_enable (bus_write_enable)
  );

  data_memory #(
    .mem_words (mem_words)
  ) mem0 (
    .clock        (clock),
    .read_enable  (bus_read_enable),
    .write_enable (bus_write_enable),
    .byte_enable  (bus_byte_enable),
    .address      (bus_address),
    .write_data   (bus_write_data),
    .read_data    (mem_read_data)
  );

  always_ff @(posedge clock) begin
    if (reset) begin
      load_pending <= 1'b0;
    end else begin
      load_pending <= take_load;
    end
  end

  // context of the load whose word comes back next cycle
  always_ff @(posedge clock) begin
    if (take_load) begin
      load_format  <= head_format;
      load_address <= head_address;
    end
  end

  // response side alignment on the registered memory word
  data_memory_interface align_rsp (
    .read_enable      (load_pending),
    .write_enable     (1'b0),
    .data_format      (load_format),
    .address          (load_address),
    .write_data       ('0),
    .read_data        (load_data),
    .bus_address      (),
    .bus_read_data    (mem_read_data),
    .bus_write_data   (),
    .bus_byte_enable  (),
    .bus_read_enable  (),
    .bus_write_enable ()
  );

  assign push = load_pending;

endmodule

/* lsu_pkg.sv */
// ##################################################################
// load/store subsystem shared definitions
// funct3 access format as a packed union, size codes, data width
// ##################################################################
package lsu_pkg;

  // data and address width
  localparam int xlen = 32;

  // bytes per data word
  localparam int byte_lanes = 4;

  // access size codes from funct3[1:0], code 3 is invalid
  localparam logic [1:0] size_byte = 2'd0;
  localparam logic [1:0] size_half = 2'd1;
  localparam logic [1:0] size_word = 2'd2;

  // decoded view of funct3
  typedef struct packed {
    logic       is_unsigned;
    logic [1:0] size;
  } format_fields_t;

  // requester writes raw, the alignment block reads fields
  typedef union packed {
    logic [2:0]     raw;
    format_fields_t fields;
  } data_format_t;

endpackage

/* lsu_request_queue.sv */
// ##################################################################
// request queue of the load/store subsystem
// in-order FIFO of requests, one credit back per dequeued entry
// ##################################################################
`timescale 1ns/1ns

module lsu_request_queue #(
  parameter int req_depth = 4
) (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        req_valid,
  input  logic                        req_write,
  input  lsu_pkg::data_format_t       req_format,
  input  logic [lsu_pkg::xlen-1:0]    req_address,
  input  logic [lsu_pkg::xlen-1:0]    req_write_data,
  output logic                        req_credit,
  output logic                        head_valid,
  output logic                        head_write,
  output lsu_pkg::data_format_t       head_format,
  output logic [lsu_pkg::xlen-1:0]    head_address,
  output logic [lsu_pkg::xlen-1:0]    head_write_data,
  input  logic                        pop
);

  localparam int ptr_w   = $clog2(req_depth);
  localparam int count_w = $clog2(req_depth + 1);

  // entry storage
  logic                        write_q   [req_depth];
  lsu_pkg::data_format_t       format_q  [req_depth];
  logic [lsu_pkg::xlen-1:0]    address_q [req_depth];
  logic [lsu_pkg::xlen-1:0]    data_q    [req_depth];

  logic [ptr_w-1:0]   wr_ptr;
  logic [ptr_w-1:0]   rd_ptr;
  logic [count_w-1:0] count;
  logic               dequeue;

  assign head_valid      = (count != '0);
  assign head_write      = write_q[rd_ptr];
  assign head_format     = format_q[rd_ptr];
  assign head_address    = address_q[rd_ptr];
  assign head_write_data = data_q[rd_ptr];

  // the requester gets its credit back as soon as the entry leaves
  assign dequeue    = pop & head_valid;
  assign req_credit = dequeue;

  // payload, no overflow check since the requester holds credits
  always_ff @(posedge clock) begin
    if (req_valid) begin
      write_q[wr_ptr]   <= req_write;
      format_q[wr_ptr]  <= req_format;
      address_q[wr_ptr] <= req_address;
      data_q[wr_ptr]    <= req_write_data;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (req_valid) begin
        wr_ptr <= (wr_ptr == ptr_w'(req_depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (dequeue) begin
        rd_ptr <= (rd_ptr == ptr_w'(req_depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({req_valid, dequeue})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* lsu_response_queue.sv */
// ##################################################################
// response queue of the load/store subsystem
// in-order FIFO of load results, sent only against consumer credits
// ##################################################################
`timescale 1ns/1ns

module lsu_response_queue #(
  parameter int rsp_depth   = 4,
  parameter int rsp_credits = 2
) (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      push,
  input  logic [lsu_pkg::xlen-1:0]  load_data,
  output logic                      room,
  output logic                      rsp_valid,
  output logic [lsu_pkg::xlen-1:0]  rsp_data,
  input  logic                      rsp_credit
);

  localparam int ptr_w    = $clog2(rsp_depth);
  localparam int count_w  = $clog2(rsp_depth + 1);
  localparam int credit_w = $clog2(rsp_credits + 1);

  logic [lsu_pkg::xlen-1:0] fifo [rsp_depth];
  logic [ptr_w-1:0]         wr_ptr;
  logic [ptr_w-1:0]         rd_ptr;
  logic [count_w-1:0]       count;
  logic [credit_w-1:0]      credit_count;
  logic                     send;

  // head goes out whenever a result and a credit are both there
  assign send      = (count != '0) && (credit_count != '0);
  assign rsp_valid = send;
  assign rsp_data  = fifo[rd_ptr];

  // a push this cycle is a result already on its way in
  assign room = (int'(count) + int'(push)) < rsp_depth;

  always_ff @(posedge clock) begin
    if (push) begin
      fifo[wr_ptr] <= load_data;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      count        <= '0;
      credit_count <= credit_w'(rsp_credits);
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == ptr_w'(rsp_depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (send) begin
        rd_ptr <= (rd_ptr == ptr_w'(rsp_depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, send})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // a returned credit and a send in one cycle cancel out
      case ({rsp_credit, send})
        2'b10:   credit_count <= credit_count + 1'b1;
        2'b01:   credit_count <= credit_count - 1'b1;
        default: credit_count <= credit_count;
      endcase
    end
  end

endmodule

/* lsu_subsystem.f */
lsu_pkg.sv
data_memory_interface.sv
data_memory.sv
lsu_request_queue.sv
lsu_access_stage.sv
lsu_response_queue.sv
lsu_subsystem.sv
lsu_tb.sv

/* lsu_subsystem.sv */
// ##################################################################
// load/store subsystem top level
// request queue, access stage with data memory, response queue
// ##################################################################
`timescale 1ns/1ns

module lsu_subsystem #(
  parameter int req_depth   = 4,
  parameter int rsp_depth   = 4,
  parameter int rsp_credits = 2,
  parameter int mem_words   = 256
) (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      req_valid,
  input  logic                      req_write,
  input  lsu_pkg::data_format_t     req_format,
  input  logic [lsu_pkg::xlen-1:0]  req_address,
  input  logic [lsu_pkg::xlen-1:0]  req_write_data,
  output logic                      req_credit,
  output logic                      rsp_valid,
  output logic [lsu_pkg::xlen-1:0]  rsp_data,
  input  logic                      rsp_credit
);

  logic                      head_valid;
  logic                      head_write;
  lsu_pkg::data_format_t     head_format;
  logic [lsu_pkg::xlen-1:0]  head_address;
  logic [lsu_pkg::xlen-1:0]  head_write_data;
  logic                      pop;
  logic                      room;
  logic                      push;
  logic [lsu_pkg::xlen-1:0]  load_data;

  lsu_request_queue #(
    .req_depth (req_depth)
  ) req_q0 (
    .clock           (clock),
    .reset           (reset),
    .req_valid       (req_valid),
    .req_write       (req_write),
    .req_format      (req_format),
    .req_address     (req_address),
    .req_write_data  (req_write_data),
    .req_credit      (req_credit),
    .head_valid      (head_valid),
    .head_write      (head_write),
    .head_format     (head_format),
    .head_address    (head_address),
    .head_write_data (head_write_data),
    .pop             (pop)
  );

  lsu_access_stage #(
    .mem_words (mem_words)
  ) access0 (
    .clock           (clock),
    .reset           (reset),
    .head_valid      (head_valid),
    .head_write      (head_write),
    .head_format     (head_format),
    .head_address    (head_address),
    .head_write_data (head_write_data),
    .pop             (pop),
    .room            (room),
    .push            (push),
    .load_data       (load_data)
  );

  lsu_response_queue #(
    .rsp_depth   (rsp_depth),
    .rsp_credits (rsp_credits)
  ) rsp_q0 (
    .clock      (clock),
    .reset      (reset),
    .push       (push),
    .load_data  (load_data),
    .room       (room),
    .rsp_valid  (rsp_valid),
    .rsp_data   (rsp_data),
    .rsp_credit (rsp_credit)
  );

endmodule

/* lsu_tb.sv */
// ####################################################################
// testbench for the load/store subsystem
// credit requester and consumer models, shadow memory, in-order checks
// ####################################################################
`timescale 1ns/1ns

module lsu_tb;

  localparam int req_depth   = 4;
  localparam int rsp_credits = 2;
  localparam int mem_bytes   = 64;
  // about 200 requests at worst-case stall fit well below this
  localparam int max_cycles  = 4000;

  logic                      clock = 1'b0;
  logic                      reset;
  logic                      req_valid;
  logic                      req_write;
  lsu_pkg::data_format_t     req_format;
  logic [lsu_pkg::xlen-1:0]  req_address;
  logic [lsu_pkg::xlen-1:0]  req_write_data;
  logic                      req_credit;
  logic                      rsp_valid;
  logic [lsu_pkg::xlen-1:0]  rsp_data;
  logic                      rsp_credit;

  logic [7:0]                shadow [mem_bytes];
  logic [lsu_pkg::xlen-1:0]  expected [$];
  integer                    seed = 32'ha908;
  string                     test_name = "reset";
  int                        credits = req_depth;
  int                        accepted = 0;
  int                        returned = 0;
  int                        rsp_sent = 0;
  int                        rsp_returned = 0;
  int                        owed = 0;
  bit                        paused = 1'b0;
  int                        cycles = 0;

  lsu_subsystem dut0 (
    .clock          (clock),
    .reset          (reset),
    .req_valid      (req_valid),
    .req_write      (req_write),
    .req_format     (req_format),
    .req_address    (req_address),
    .req_write_data (req_write_data),
    .req_credit     (req_credit),
    .rsp_valid      (rsp_valid),
    .rsp_data       (rsp_data),
    .rsp_credit     (rsp_credit)
  );

  always #4 clock = ~clock;

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped");
  endtask

  task automatic value_error(input logic [31:0] exp, input logic [31:0] act);
    $display("ERR %s expected %h actual %h", test_name, exp, act);
    stop_run("load result mismatch");
  endtask

  // load result from the shadow bytes, funct3 bit 2 selects zero extension
  function automatic logic [31:0] expected_load(input logic [2:0] fmt, input int addr);
    logic [31:0] word;
    int          n;
    word = '0;
    if (fmt[1:0] == 2'd3) begin
      return '0;
    end
    n = 1 << fmt[1:0];
    for (int i = 0; i < n; i++) begin
      word[8*i +: 8] = shadow[addr + i];
    end
    if (!fmt[2] && n == 1) begin
      word[31:8] = {24{word[7]}};
    end
    if (!fmt[2] && n == 2) begin
      word[31:16] = {16{word[15]}};
    end
    return word;
  endfunction

  // one request, spends a credit, caller sits 1 ns after a rising edge
  task automatic send_request(input logic write, input logic [2:0] fmt, input int addr,
                              input logic [31:0] data);
    int n;
    while (credits == 0) begin
      @(posedge clock);
      #1;
    end
    req_valid      = 1'b1;
    req_write      = write;
    req_format.raw = fmt;
    req_address    = addr;
    req_write_data = data;
    credits--;
    accepted++;
    if (write && fmt[1:0] != 2'd3) begin
      n = 1 << fmt[1:0];
      for (int i = 0; i < n; i++) begin
        shadow[addr + i] = data[8*i +: 8];
      end
    end else if (!write) begin
      expected.push_back(expected_load(fmt, addr));
    end
    @(posedge clock);
    #1;
    req_valid = 1'b0;
  endtask

  // each test ends with a load, so every request has left the queue by now
  task automatic drain();
    while (expected.size() != 0 || owed != 0) begin
      @(posedge clock);
      #1;
    end
    assert (returned == accepted) else stop_run("request credits missing after drain");
  endtask

  // outputs are settled at the falling edge
  always @(negedge clock) begin
    if (!reset) begin
      if (req_credit) begin
        returned++;
        credits++;
      end
      assert (returned <= accepted) else stop_run("more request credits than requests");
      if (rsp_valid) begin
        rsp_sent++;
        owed++;
        assert (expected.size() != 0) else stop_run("response without a pending load");
        assert (rsp_sent <= rsp_credits + rsp_returned)
          else stop_run("response sent without credit");
        assert (rsp_data === expected[0]) else value_error(expected[0], rsp_data);
        void'(expected.pop_front());
      end
      if (rsp_credit) begin
        rsp_returned++;
      end
    end
  end

  // consumer hands back one credit per cycle unless paused
  always @(posedge clock) begin
    #1;
    if (!paused && owed > 0) begin
      rsp_credit = 1'b1;
      owed--;
    end else begin
      rsp_credit = 1'b0;
    end
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles >= max_cycles) begin
      stop_run("timeout, the run did not finish within the cycle limit");
    end
  end

  initial begin
    int addr;
    int sent_before;
    reset = 1'b1;
    req_valid = 1'b0;
    req_write = 1'b0;
    req_format = '0;
    req_address = '0;
    req_write_data = '0;
    rsp_credit = 1'b0;
    repeat (2) @(posedge clock);
    #1;
    reset = 1'b0;

    // every word gets a known value first
    test_name = "word_roundtrip";
    for (int w = 0; w < mem_bytes / 4; w++) begin
      send_request(1'b1, 3'd2, 4 * w, $random(seed));
    end
    for (int w = 0; w < mem_bytes / 4; w++) begin
      send_request(1'b0, 3'd2, 4 * w, '0);
    end
    drain();

    test_name = "lane_merge";
    for (int k = 0; k < 4; k++) begin
      addr = ($random(seed) & 15) * 4;
      for (int off = 0; off < 4; off++) begin
        send_request(1'b1, 3'd0, addr + off, $random(seed));
        send_request(1'b0, 3'd2, addr, '0);
      end
      for (int off = 0; off < 4; off += 2) begin
        send_request(1'b1, 3'd1, addr + off, $random(seed));
        send_request(1'b0, 3'd2, addr, '0);
      end
    end
    drain();

    // lb, lbu, lh, lhu on random words
    test_name = "extension";
    for (int k = 0; k < 8; k++) begin
      addr = ($random(seed) & 15) * 4;
      send_request(1'b1, 3'd2, addr, $random(seed));
      for (int off = 0; off < 4; off++) begin
        send_request(1'b0, 3'd0, addr + off, '0);
        send_request(1'b0, 3'd4, addr + off, '0);
      end
      for (int off = 0; off < 4; off += 2) begin
        send_request(1'b0, 3'd1, addr + off, '0);
        send_request(1'b0, 3'd5, addr + off, '0);
      end
    end
    drain();

    // consumer stalls, both queues fill, requester runs out of credits
    test_name = "response_credits";
    sent_before = rsp_sent;
    paused = 1'b1;
    for (int k = 0; k < 10; k++) begin
      send_request(1'b0, 3'd2, 4 * k, '0);
    end
    repeat (20) @(posedge clock);
    #1;
    assert (rsp_sent - sent_before == rsp_credits)
      else stop_run("wrong response count while paused");
    assert (credits == 0) else stop_run("requester kept credits under back-pressure");
    paused = 1'b0;
    drain();

    test_name = "invalid_format";
    for (int k = 0; k < 4; k++) begin
      addr = ($random(seed) & 15) * 4;
      send_request(1'b1, (k % 2) ? 3'd7 : 3'd3, addr, $random(seed));
      send_request(1'b0, 3'd2, addr, '0);
      send_request(1'b0, (k % 2) ? 3'd7 : 3'd3, addr, '0);
    end
    drain();

    $display("*** PASSED ***");
    $finish;
  end

endmodule
